// File: main_bus_cases.txt
# op addr wdata expect name (hex fields)
# W write, R read and compare, B set input group (addr) to wdata, I irq write with latch check
R 2000 00 00 gfx1_after_reset
R 4003 00 00 gfx2_after_reset
W 1000 a5 00 ram_wr_low
W 1fff 3c 00 ram_wr_high
R 1000 00 a5 ram_rd_low
R 1fff 00 3c ram_rd_high
W 0c00 11 00 pal_wr_low
W 0fff 22 00 pal_wr_high
R 0c00 00 11 pal_rd_low
R 0fff 00 22 pal_rd_high
R 0800 00 ff unmapped_0800
R 0020 00 ff unmapped_0020
R 6010 00 4a rom_bank0
W 7000 03 00 bank_wr
R 6123 00 79 rom_bank3_low
R 7fff 00 a5 rom_bank3_high
R 8456 00 0c rom_fixed
R ffff 00 a5 rom_top
B 0000 1b 00 set_cab
B 0001 25 00 set_joy1
B 0002 1a 00 set_joy2
B 0004 c3 00 set_dip_a
B 0005 5e 00 set_dip_b
B 0006 09 00 set_dip_c
R 0010 00 fb port0
R 0011 00 ea port1_joy1
R 0012 00 d5 port2_joy2
R 0013 00 ff port3_unused
R 0014 00 c3 port4_dip_a
R 0015 00 5e port5_dip_b
R 0016 00 f9 port6_dip_c
W 001c 77 00 latch_wr
I 001a 00 77 irq_pulse
W 2005 81 00 gfx1_wr
W 4005 42 00 gfx2_wr
R 2005 00 81 gfx1_rd
R 4005 00 42 gfx2_rd
R 2000 00 00 gfx1_other_reg
R 200d 00 81 gfx1_mirror

// File: filelist.f
main_pkg.sv
cpu_bus_if.sv
bus_cen_gen.sv
main_decoder.sv
bus_ram.sv
gfx_reg_bank.sv
main_bus_top.sv
tb_main_bus.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_main_bus
FILELIST  = filelist.f
LOG       = sim.log

.PHONY: sim clean

# Pass or fail comes from the log, not from the exit code of the run
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb_main_bus.sv
`timescale 1ns/1ns

module tb_main_bus;
    import main_pkg::*;

    localparam int CEN_DIV   = 8;
    localparam int MAX_CASES = 64;

    logic       clk;
    logic       rst;
    addr_t      addr;
    logic       rnw;
    data_t      cpu_dout;
    logic       cpu_cen;
    data_t      cpu_din;
    logic [1:0] start_button;
    logic [1:0] coin_input;
    logic [5:0] joystick1;
    logic [5:0] joystick2;
    logic       service;
    data_t      dipsw_a;
    data_t      dipsw_b;
    logic [3:0] dipsw_c;
    rom_addr_t  rom_addr;
    logic       rom_cs;
    data_t      rom_data;
    logic       rom_ok = 1'b0;
    logic       snd_irq;
    data_t      snd_latch;

    // Case table
    byte   c_op    [MAX_CASES];
    addr_t c_addr  [MAX_CASES];
    data_t c_wdata [MAX_CASES];
    data_t c_exp   [MAX_CASES];
    string c_name  [MAX_CASES];
    int    n_cases = 0;
    logic  loaded  = 1'b0;

    int        errors   = 0;
    int        n_ok     = 0;
    bank_t     bank_model;
    logic [31:0] lfsr   = 32'hd31597e0;
    rom_addr_t rom_last;
    logic      rom_wait;
    logic [3:0] rom_delay;

    main_bus_top #(.CEN_DIV(CEN_DIV)) u_main_bus_top (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Taps 32, 22, 2, 1; one step per bit
    function automatic logic [3:0] rand_nibble();
        logic [3:0] r;
        logic       fb;
        r = '0;
        for (int i = 0; i < 4; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[2:0], fb};
        end
        return r;
    endfunction

    // ROM model, data only valid once ready
    assign rom_data = rom_ok ? (rom_addr[7:0] ^ 8'h5a) : 8'h00;

    always @(posedge clk) begin
        if (rst) begin
            rom_ok   <= 1'b0;
            rom_wait <= 1'b0;
            rom_last <= '1;
        end else if (rom_addr != rom_last) begin
            // New address, restart the random latency
            rom_last  <= rom_addr;
            rom_ok    <= 1'b0;
            rom_wait  <= 1'b1;
            rom_delay <= rand_nibble();
        end else if (rom_wait) begin
            if (rom_delay == 4'd0) begin
                rom_ok   <= 1'b1;
                rom_wait <= 1'b0;
            end else begin
                rom_delay <= rom_delay - 4'd1;
            end
        end
    end

    // No CPU cycle may end while the ROM is still busy
    always @(negedge clk) begin
        if (!rst && rom_cs && !rom_ok) begin
            assert (!cpu_cen) else begin
                $display("cpu_cen pulsed while the ROM data was not ready at %0t", $time);
                errors++;
            end
        end
    end

    task automatic check_value(string name, string what, logic [16:0] exp, logic [16:0] act);
        assert (exp == act) else begin
            $display("** Error %s (%s): expected %h, actual %h", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic load_cases();
        int          fd;
        int          cnt;
        string       line;
        byte         op;
        logic [15:0] a;
        logic [7:0]  d;
        logic [7:0]  e;
        string       nm;
        fd = $fopen("main_bus_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file main_bus_cases.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;
            cnt = $sscanf(line, "%c %h %h %h %s", op, a, d, e, nm);
            if (cnt == 5 && n_cases < MAX_CASES) begin
                c_op[n_cases]    = op;
                c_addr[n_cases]  = a;
                c_wdata[n_cases] = d;
                c_exp[n_cases]   = e;
                c_name[n_cases]  = nm;
                n_cases++;
            end
        end
        $fclose(fd);
    endtask

    // Negedge inside the cycle where cen is high
    task automatic wait_cen();
        do @(negedge clk); while (!cpu_cen);
    endtask

    // One CPU access, starting right after the previous cen edge
    task automatic bus_cycle(addr_t a, logic r, data_t d);
        @(posedge clk);
        #1;
        addr     = a;
        rnw      = r;
        cpu_dout = d;
        wait_cen();
    endtask

    task automatic set_inputs(addr_t grp, data_t v);
        case (grp[2:0])
            3'd0: begin
                start_button = v[4:3];
                service      = v[2];
                coin_input   = v[1:0];
            end
            3'd1: joystick1 = v[5:0];
            3'd2: joystick2 = v[5:0];
            3'd4: dipsw_a = v;
            3'd5: dipsw_b = v;
            3'd6: dipsw_c = v[3:0];
            default: begin
                $display("Unknown input group %h in the case file", grp);
                errors++;
            end
        endcase
    endtask

    task automatic run_case(int i);
        int        err_before;
        rom_addr_t exp_rom;
        logic      in_rom;
        err_before = errors;
        case (c_op[i])
            "B": begin
                // Inputs change inside an idle CPU cycle
                @(posedge clk);
                #1;
                set_inputs(c_addr[i], c_wdata[i]);
                wait_cen();
            end
            "W": begin
                bus_cycle(c_addr[i], 1'b0, c_wdata[i]);
                // ROM select is for reads only
                check_value(c_name[i], "rom_cs", 17'd0, {16'd0, rom_cs});
                if (c_addr[i][15:12] == 4'h7) bank_model = c_wdata[i][3:0];
            end
            "R": begin
                bus_cycle(c_addr[i], 1'b1, 8'h00);
                check_value(c_name[i], "cpu_din", {9'd0, c_exp[i]}, {9'd0, cpu_din});
                // Linear upper half, banked window at 0x6000
                in_rom = c_addr[i][15] || c_addr[i][15:13] == 3'b011;
                check_value(c_name[i], "rom_cs", {16'd0, in_rom}, {16'd0, rom_cs});
                if (in_rom) begin
                    exp_rom = c_addr[i][15] ? {2'b00, c_addr[i][14:0]}
                                            : {bank_model + 4'd4, c_addr[i][12:0]};
                    check_value(c_name[i], "rom_addr", exp_rom, rom_addr);
                end
            end
            "I": begin
                bus_cycle(c_addr[i], 1'b0, c_wdata[i]);
                @(posedge clk);
                #1;
                check_value(c_name[i], "snd_irq set", 17'd1, {16'd0, snd_irq});
                addr = 16'h0800;
                rnw  = 1'b1;
                wait_cen();
                check_value(c_name[i], "snd_irq held", 17'd1, {16'd0, snd_irq});
                check_value(c_name[i], "snd_latch", {9'd0, c_exp[i]}, {9'd0, snd_latch});
                @(posedge clk);
                #1;
                check_value(c_name[i], "snd_irq cleared", 17'd0, {16'd0, snd_irq});
                wait_cen();
            end
            default: begin
                $display("Unknown operation in case %s", c_name[i]);
                errors++;
            end
        endcase
        if (errors == err_before) begin
            n_ok++;
            $display("case %0d %s ok", i, c_name[i]);
        end else begin
            $display("case %0d %s FAILED", i, c_name[i]);
        end
    endtask

    initial begin
        rst          = 1'b1;
        addr         = 16'h0800;
        rnw          = 1'b1;
        cpu_dout     = 8'h00;
        start_button = 2'b00;
        coin_input   = 2'b00;
        joystick1    = 6'h00;
        joystick2    = 6'h00;
        service      = 1'b0;
        dipsw_a      = 8'h00;
        dipsw_b      = 8'h00;
        dipsw_c      = 4'h0;
        bank_model   = 4'd0;
        load_cases();
        if (n_cases == 0) begin
            $display("No cases were loaded");
            errors++;
        end
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        wait_cen();
        for (int i = 0; i < n_cases; i++) begin
            run_case(i);
        end
        $display("Cases run: %0d, ok: %0d, errors: %0d", n_cases, n_ok, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Generous bound per case, stalls included
    initial begin
        wait (loaded);
        repeat ((n_cases + 1) * CEN_DIV * 24) @(posedge clk);
        $display("Timeout, the cases did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: main_bus_top.sv
`timescale 1ns/1ns

module main_bus_top #(
    parameter int CEN_DIV = 8
) (
    input  logic                clk,
    input  logic                rst,
    // CPU
    input  main_pkg::addr_t     addr,
    input  logic                rnw,
    input  main_pkg::data_t     cpu_dout,
    output logic                cpu_cen,
    output main_pkg::data_t     cpu_din,
    // Cabinet
    input  logic [1:0]          start_button,
    input  logic [1:0]          coin_input,
    input  logic [5:0]          joystick1,
    input  logic [5:0]          joystick2,
    input  logic                service,
    // DIP switches
    input  main_pkg::data_t     dipsw_a,
    input  main_pkg::data_t     dipsw_b,
    input  logic [3:0]          dipsw_c,
    // External ROM
    output main_pkg::rom_addr_t rom_addr,
    output logic                rom_cs,
    input  main_pkg::data_t     rom_data,
    input  logic                rom_ok,
    // Sound CPU
    output logic                snd_irq,
    output main_pkg::data_t     snd_latch
);
    import main_pkg::*;

    logic  ram_cs;
    logic  pal_cs;
    logic  gfx1_cs;
    logic  gfx2_cs;
    data_t ram_dout;
    data_t pal_dout;
    data_t gfx1_dout;
    data_t gfx2_dout;

    cpu_bus_if bus ();

    // CPU drives the shared bus
    assign bus.addr  = addr;
    assign bus.rnw   = rnw;
    assign bus.wdata = cpu_dout;
    assign cpu_cen   = bus.cen;

    // CPU cycle timing, held back by the ROM
    bus_cen_gen #(
        .CEN_DIV (CEN_DIV)
    ) u_cen_gen (
        .clk    (clk),
        .rst    (rst),
        .rom_cs (rom_cs),
        .rom_ok (rom_ok),
        .cen    (bus.cen)
    );

    main_decoder u_decoder (
        .bus          (bus.decoder),
        .clk          (clk),
        .rst          (rst),
        .gfx1_cs      (gfx1_cs),
        .gfx2_cs      (gfx2_cs),
        .gfx1_dout    (gfx1_dout),
        .gfx2_dout    (gfx2_dout),
        .ram_dout     (ram_dout),
        .pal_dout     (pal_dout),
        .rom_data     (rom_data),
        .start_button (start_button),
        .coin_input   (coin_input),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .service      (service),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .dipsw_c      (dipsw_c),
        .ram_cs       (ram_cs),
        .pal_cs       (pal_cs),
        .rom_cs       (rom_cs),
        .rom_addr     (rom_addr),
        .cpu_din      (cpu_din),
        .snd_irq      (snd_irq),
        .snd_latch    (snd_latch)
    );

    // 4 KB work RAM
    bus_ram #(.AW(12)) u_work_ram (
        .bus  (bus.mem),
        .clk  (clk),
        .cs   (ram_cs),
        .dout (ram_dout)
    );

    // 1 KB palette
    bus_ram #(.AW(10)) u_pal_ram (
        .bus  (bus.mem),
        .clk  (clk),
        .cs   (pal_cs),
        .dout (pal_dout)
    );

    gfx_reg_bank #(.BASE(GFX1_BASE)) u_gfx1_regs (
        .bus  (bus.mem),
        .clk  (clk),
        .rst  (rst),
        .cs   (gfx1_cs),
        .dout (gfx1_dout)
    );

    gfx_reg_bank #(.BASE(GFX2_BASE)) u_gfx2_regs (
        .bus  (bus.mem),
        .clk  (clk),
        .rst  (rst),
        .cs   (gfx2_cs),
        .dout (gfx2_dout)
    );

endmodule

// File: gfx_reg_bank.sv
`timescale 1ns/1ns

module gfx_reg_bank #(
    parameter main_pkg::addr_t BASE = main_pkg::GFX1_BASE
) (
    cpu_bus_if.mem          bus,
    input  logic            clk,
    input  logic            rst,
    output logic            cs,
    output main_pkg::data_t dout
);
    import main_pkg::*;

    data_t      regs [8];
    logic [2:0] sel;

    // Whole 8 KB window, registers mirror every eight bytes
    assign cs  = bus.addr[15:13] == BASE[15:13];
    assign sel = bus.addr[2:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (bus.cen && cs && !bus.rnw) begin
            regs[sel] <= bus.wdata;
        end
    end

    // Registered read, the decoder picks it up through cs
    always_ff @(posedge clk) begin
        dout <= regs[sel];
    end

endmodule

// File: bus_ram.sv
`timescale 1ns/1ns

module bus_ram #(
    parameter int AW = 12
) (
    cpu_bus_if.mem          bus,
    input  logic            clk,
    input  logic            cs,
    output main_pkg::data_t dout
);
    import main_pkg::*;

    data_t mem [2**AW];

    logic [AW-1:0] addr;

    // Upper address bits are already covered by cs
    assign addr = bus.addr[AW-1:0];

    // Write lands on the cen edge that ends the access
    always_ff @(posedge clk) begin
        if (bus.cen && cs && !bus.rnw) begin
            mem[addr] <= bus.wdata;
        end
    end

    // Read every clock, valid long before the next cen
    always_ff @(posedge clk) begin
        dout <= mem[addr];
    end

endmodule

// File: main_decoder.sv
`timescale 1ns/1ns

module main_decoder (
    cpu_bus_if.decoder            bus,
    input  logic                  clk,
    input  logic                  rst,
    // Graphics windows decode themselves
    input  logic                  gfx1_cs,
    input  logic                  gfx2_cs,
    input  main_pkg::data_t       gfx1_dout,
    input  main_pkg::data_t       gfx2_dout,
    // Memories
    input  main_pkg::data_t       ram_dout,
    input  main_pkg::data_t       pal_dout,
    input  main_pkg::data_t       rom_data,
    // Cabinet
    input  logic [1:0]            start_button,
    input  logic [1:0]            coin_input,
    input  logic [5:0]            joystick1,
    input  logic [5:0]            joystick2,
    input  logic                  service,
    // DIP switches
    input  main_pkg::data_t       dipsw_a,
    input  main_pkg::data_t       dipsw_b,
    input  logic [3:0]            dipsw_c,
    // Selects
    output logic                  ram_cs,
    output logic                  pal_cs,
    output logic                  rom_cs,
    output main_pkg::rom_addr_t   rom_addr,
    // Back to the CPU
    output main_pkg::data_t       cpu_din,
    // Sound CPU side
    output logic                  snd_irq,
    output main_pkg::data_t       snd_latch
);
    import main_pkg::*;

    logic  bank_cs;
    logic  in_cs;
    logic  out_cs;
    bank_t bank;
    data_t port_in;

    // Chip selects
    always_comb begin
        // Fixed upper 32 KB plus the 8 KB banked window below it
        rom_cs  = (bus.addr[15] || bus.addr[15:13] == 3'b011) && bus.rnw;
        // Bank register shares the upper half of the window, write only
        bank_cs = bus.addr[15:12] == 4'b0111 && !bus.rnw;
        ram_cs  = bus.addr[15:12] == 4'b0001;
        pal_cs  = bus.addr[15:10] == 6'b0000_11;
        // 0x0010 to 0x001F
        in_cs   = bus.addr[15:4] == 12'h001 && bus.rnw;
        // 0x0018 to 0x001F
        out_cs  = bus.addr[15:3] == 13'h0003 && !bus.rnw;
    end

    // Read mux, first match wins
    always_comb begin
        if (rom_cs) begin
            cpu_din = rom_data;
        end else if (ram_cs) begin
            cpu_din = ram_dout;
        end else if (pal_cs) begin
            cpu_din = pal_dout;
        end else if (in_cs) begin
            cpu_din = port_in;
        end else if (gfx1_cs) begin
            cpu_din = gfx1_dout;
        end else if (gfx2_cs) begin
            cpu_din = gfx2_dout;
        end else begin
            cpu_din = OPEN_BUS;
        end
    end

    // 0x8000 up is linear, lower window goes through the bank
    always_comb begin
        if (bus.addr[15]) begin
            rom_addr = {2'b00, bus.addr[14:0]};
        end else begin
            rom_addr = {bank + BANK_OFFSET, bus.addr[12:0]};
        end
    end

    // Input ports, sampled every clock
    always_ff @(posedge clk) begin
        case (bus.addr[2:0])
            3'd0: port_in <= {3'b111, start_button, service, coin_input};
            // Joystick lines are crossed in pairs on the board
            3'd1: port_in <= {2'b11, joystick1[5:4], joystick1[2], joystick1[3],
                              joystick1[0], joystick1[1]};
            3'd2: port_in <= {2'b11, joystick2[5:4], joystick2[2], joystick2[3],
                              joystick2[0], joystick2[1]};
            3'd4: port_in <= dipsw_a;
            3'd5: port_in <= dipsw_b;
            3'd6: port_in <= {4'hf, dipsw_c};
            default: port_in <= OPEN_BUS;
        endcase
    end

    // Bank register and output latches
    always_ff @(posedge clk) begin
        if (rst) begin
            bank      <= '0;
            snd_irq   <= 1'b0;
            snd_latch <= '0;
        end else if (bus.cen) begin
            // IRQ lasts a single CPU cycle
            snd_irq <= 1'b0;
            if (bank_cs) begin
                bank <= bus.wdata[3:0];
            end
            if (out_cs) begin
                // Coin counters and watchdog are not modelled
                case (bus.addr[2:1])
                    2'b01: snd_irq <= 1'b1;
                    2'b10: snd_latch <= bus.wdata;
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: bus_cen_gen.sv
`timescale 1ns/1ns

module bus_cen_gen #(
    parameter int CEN_DIV = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic rom_cs,
    input  logic rom_ok,
    output logic cen
);
    import main_pkg::*;

    localparam int CNT_W = $clog2(CEN_DIV);

    cen_state_t       state;
    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= COUNT;
            cnt   <= '0;
            cen   <= 1'b0;
        end else begin
            // Pulse is one clock wide by default
            cen <= 1'b0;
            case (state)
                COUNT: begin
                    if (cnt == CNT_W'(CEN_DIV - 1)) begin
                        cnt <= '0;
                        // ROM byte not there yet, stretch the cycle
                        if (rom_cs && !rom_ok) begin
                            state <= WAIT_ROM;
                        end else begin
                            cen <= 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                WAIT_ROM: begin
                    // End the access right after data shows up
                    if (rom_ok) begin
                        cen   <= 1'b1;
                        cnt   <= '0;
                        state <= COUNT;
                    end
                end
                default: begin
                    state <= COUNT;
                    cnt   <= '0;
                end
            endcase
        end
    end

endmodule

// File: cpu_bus_if.sv
`timescale 1ns/1ns

interface cpu_bus_if;
    import main_pkg::*;

    // Held by the CPU from one cen pulse to the next
    addr_t addr;
    logic  rnw;
    data_t wdata;
    // One clock wide, marks the end of each CPU cycle
    logic  cen;

    // Address decoder only looks at the bus
    modport decoder (input addr, rnw, wdata, cen);

    // Memories and register windows on the bus
    modport mem (input addr, rnw, wdata, cen);

    // Bus master side
    modport src (output addr, rnw, wdata, cen);

endinterface

// File: main_pkg.sv
package main_pkg;

    // CPU side of the bus
    typedef logic [15:0] addr_t;
    typedef logic [7:0]  data_t;

    // 128 KB of ROM behind the banked window
    typedef logic [16:0] rom_addr_t;
    typedef logic [3:0]  bank_t;

    // Clock-enable generator states
    typedef enum logic {
        COUNT,
        WAIT_ROM
    } cen_state_t;

    // Graphics register windows, 8 KB each
    localparam addr_t GFX1_BASE = 16'h2000;
    localparam addr_t GFX2_BASE = 16'h4000;

    // Banked ROM starts four banks up, the first 32 KB are the fixed upper half
    localparam bank_t BANK_OFFSET = 4'd4;

    // Value seen by the CPU when nothing drives the bus
    localparam data_t OPEN_BUS = 8'hff;

endpackage
